// ==== redraw_board.f ====
verilog/mines_pkg.sv
verilog/cell_ram.sv
verilog/cell_arbiter.sv
verilog/flag_marker.sv
verilog/defuse_unit.sv
verilog/symbol_fetch.sv
verilog/redraw_board.sv
testbench/redraw_board_assert.sv
testbench/tb_redraw_board.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with Verilator, run, and look for the pass message in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_redraw_board \
    -f redraw_board.f -o sim_redraw_board > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }
./obj_dir/sim_redraw_board > sim.log 2>&1
grep -q "ALL CHECKS PASSED" sim.log && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }

// ==== testbench/tb_redraw_board.sv ====
`timescale 1ns/1ps

module tb_redraw_board import mines_pkg::*; ();

    localparam int CYCLE_LIMIT = 20000;    // all tests take about 3k cycles

    logic         clk;
    logic         rst_n;
    logic         mark_flag;
    logic         defuse;
    logic [3:0]   symbol_x;
    logic [3:0]   symbol_y;
    level_t       level;
    logic [255:0] mine_map;
    logic         scan_valid;
    logic [3:0]   scan_x;
    logic [3:0]   scan_y;
    logic         symbol_valid;
    symbol_t      symbol;
    logic         explode;
    logic [3:0]   blast_x;
    logic [3:0]   blast_y;
    logic [5:0]   mines;
    logic [5:0]   mines_left;
    logic         busy;

    logic [15:0] lfsr = 16'd23132;
    cell_t       board [256];    // reference board indexed by y*16+x
    logic [7:0]  scan_q [$];     // {y, x} of scans in flight
    logic [7:0]  popped;
    logic [7:0]  pend_cell;      // cell whose symbol may change mid scan
    logic        pend_on;
    logic        blasted;
    int          blast_idx;
    int          side;
    int          mine_total;
    int          flags;
    int          checks;
    int          errors;
    int          cycles = 0;

    redraw_board #(.MAX_SIDE(16)) dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // ====================
    // random numbers and reference model

    function automatic logic next_bit();
        logic fb;
        fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];    // x^16+x^14+x^13+x^11+1
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic int random_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(next_bit());
        end
        return v;
    endfunction

    function automatic int neighbour_mines(input int x, input int y);
        int n;
        n = 0;
        for (int dy = -1; dy <= 1; dy++) begin
            for (int dx = -1; dx <= 1; dx++) begin
                if ((dx != 0 || dy != 0) && x + dx >= 0 && y + dy >= 0 &&
                    x + dx < side && y + dy < side) begin
                    n += int'(mine_map[(y + dy) * 16 + x + dx]);
                end
            end
        end
        return n;
    endfunction

    function automatic int mines_in_square();
        int n;
        n = 0;
        for (int i = 0; i < 256; i++) begin
            if (i % 16 < side && i / 16 < side && mine_map[i]) begin
                n++;
            end
        end
        return n;
    endfunction

    // kind 0 hidden safe cell, 1 flagged cell, 2 unflagged mine
    function automatic int first_cell(input int kind);
        for (int i = 0; i < 256; i++) begin
            if (i % 16 < side && i / 16 < side) begin
                if ((kind == 0 && !mine_map[i] && !board[i].flagged && !board[i].revealed) ||
                    (kind == 1 && board[i].flagged) ||
                    (kind == 2 && mine_map[i] && !board[i].flagged)) begin
                    return i;
                end
            end
        end
        return -1;
    endfunction

    function automatic logic [5:0] expected_symbol(input int idx);
        if (blasted && idx == blast_idx) begin
            return {SYM_MINE, 4'd0};
        end else if (board[idx].flagged) begin
            return {SYM_FLAG, 4'd0};
        end else if (board[idx].revealed) begin
            return {SYM_NUMBER, board[idx].count};
        end
        return {SYM_HIDDEN, 4'd0};
    endfunction

    function automatic int expected_left();
        return (mine_total > flags) ? mine_total - flags : 0;    // clamped at zero
    endfunction

    // ====================
    // tasks

    task automatic compare_value(input string name, input int expected, input int actual);
        checks++;
        if (expected != actual) begin
            errors++;
            $display("Error at %0d ns: %s expected 0x%0h, got 0x%0h",
                $time, name, expected, actual);
        end
    endtask

    task automatic report_test(input int num, input string name);
        $display("test %0d (%s) finished, %0d errors so far", num, name, errors);
    endtask

    task automatic start_game(input level_t lvl);
        @(negedge clk);
        rst_n = 1'b0;
        level = lvl;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        side = (lvl == LVL_EASY) ? 8 : (lvl == LVL_MEDIUM) ? 10 : 16;
        for (int i = 0; i < 256; i++) begin
            board[i] = '0;
        end
        flags = 0;
        blasted = 1'b0;
        mine_total = mines_in_square();
    endtask

    task automatic run_command(input logic is_flag, input int x, input int y);
        int   idx;
        logic acts;
        idx = y * 16 + x;
        acts = x < side && y < side && !blasted;
        @(negedge clk);
        symbol_x = 4'(x);
        symbol_y = 4'(y);
        mark_flag = is_flag;
        defuse = !is_flag;
        repeat (2) @(negedge clk);
        mark_flag = 1'b0;
        defuse = 1'b0;
        compare_value("busy", int'(acts), int'(busy));    // accepted commands still working
        while (busy) begin
            @(negedge clk);
        end
        if (acts) begin
            if (is_flag && !board[idx].revealed) begin
                board[idx].flagged = !board[idx].flagged;
                flags = board[idx].flagged ? flags + 1 : flags - 1;
            end else if (!is_flag && !board[idx].flagged && !board[idx].revealed) begin
                if (mine_map[idx]) begin
                    blasted = 1'b1;
                    blast_idx = idx;
                end else begin
                    board[idx].revealed = 1'b1;
                    board[idx].count = 4'(neighbour_mines(x, y));
                end
            end
        end
        compare_value("mines_left", expected_left(), int'(mines_left));
        compare_value("explode", int'(blasted), int'(explode));
    endtask

    task automatic scan_board();
        for (int y = 0; y < side; y++) begin
            for (int x = 0; x < side; x++) begin
                @(negedge clk);
                scan_valid = 1'b1;
                scan_x = 4'(x);
                scan_y = 4'(y);
                scan_q.push_back(8'(y * 16 + x));
            end
        end
        @(negedge clk);
        scan_valid = 1'b0;
        while (scan_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic defuse_during_scan(input int x, input int y);
        pend_cell = 8'(y * 16 + x);
        pend_on = 1'b1;
        fork
            run_command(1'b0, x, y);
            scan_board();
        join
        pend_on = 1'b0;
    endtask

    // pair each symbol with the oldest scan
    always @(negedge clk) begin
        if (symbol_valid) begin
            if (scan_q.size() == 0) begin
                errors++;
                $display("symbol_valid came with no scan in flight at %0d ns", $time);
            end else begin
                popped = scan_q.pop_front();
                if (!(pend_on && popped == pend_cell)) begin
                    compare_value($sformatf("symbol(%0d,%0d)", popped[3:0], popped[7:4]),
                        int'(expected_symbol(int'(popped))), int'(symbol));
                end
            end
        end
    end

    // ====================
    // test sequence

    initial begin
        int x;
        int y;
        int idx;
        rst_n = 1'b0;
        mark_flag = 1'b0;
        defuse = 1'b0;
        symbol_x = '0;
        symbol_y = '0;
        level = LVL_HARD;
        scan_valid = 1'b0;
        scan_x = '0;
        scan_y = '0;
        checks = 0;
        errors = 0;
        pend_on = 1'b0;
        pend_cell = '0;
        blasted = 1'b0;
        blast_idx = -1;
        flags = 0;
        side = 16;
        mine_map = '0;
        for (int i = 0; i < 256; i++) begin
            if ($countones(mine_map) < 59 && random_bits(5) < 5) begin    // about 1 in 6
                mine_map[i] = 1'b1;
            end
        end
        x = random_bits(3);
        y = random_bits(3);
        mine_map[y * 16 + x] = 1'b1;    // at least one mine on the easy board

        start_game(LVL_HARD);
        scan_board();
        compare_value("mines", mine_total, int'(mines));
        compare_value("mines_left", mine_total, int'(mines_left));
        report_test(1, "blank hard board");

        x = random_bits(4);
        y = random_bits(4);
        run_command(1'b1, x, y);
        scan_board();
        run_command(1'b1, x, y);    // second toggle hides it again
        scan_board();
        while (flags <= mine_total + 1) begin    // push the count past zero
            x = random_bits(4);
            y = random_bits(4);
            run_command(1'b1, x, y);
        end
        scan_board();
        report_test(2, "flag toggle and mines_left");

        idx = first_cell(1);
        if (idx < 0) begin
            errors++;
            $display("no flagged cell left to try a defuse on");
        end else begin
            run_command(1'b0, idx % 16, idx / 16);
        end
        idx = first_cell(0);
        if (idx < 0) begin
            errors++;
            $display("no hidden safe cell left to reveal");
        end else begin
            run_command(1'b0, idx % 16, idx / 16);
            run_command(1'b1, idx % 16, idx / 16);
        end
        scan_board();
        report_test(4, "flagged and revealed cells hold");

        start_game(LVL_MEDIUM);
        for (int i = 0; i < 12; i++) begin
            if (i < 4) begin
                x = (i % 2) * 9;    // corners
                y = (i / 2) * 9;
            end else begin
                x = (i == 4) ? 0 : random_bits(4) % 10;
                y = (i == 5) ? 9 : random_bits(4) % 10;
            end
            if (!mine_map[y * 16 + x]) begin
                if (i % 2 == 1) begin
                    defuse_during_scan(x, y);
                end else begin
                    run_command(1'b0, x, y);
                end
            end
        end
        scan_board();
        report_test(3, "medium reveal with contention");

        start_game(LVL_EASY);
        for (int i = 0; i < 4; i++) begin
            x = 8 + random_bits(3);
            y = random_bits(4);
            if (i < 2) begin
                run_command(1'(i % 2), x, y);
            end else begin
                run_command(1'(i % 2), y, x);
            end
        end
        scan_board();
        compare_value("mines", mine_total, int'(mines));
        report_test(5, "easy board ignores outside cells");

        x = random_bits(3);
        y = random_bits(3);
        if (!mine_map[y * 16 + x]) begin
            run_command(1'b1, x, y);
        end
        idx = first_cell(2);
        if (idx < 0) begin
            errors++;
            $display("no unflagged mine on the easy board to detonate");
        end else begin
            run_command(1'b0, idx % 16, idx / 16);
            compare_value("blast_x", idx % 16, int'(blast_x));
            compare_value("blast_y", idx / 16, int'(blast_y));
        end
        scan_board();
        idx = first_cell(0);
        if (idx >= 0) begin
            run_command(1'b0, idx % 16, idx / 16);
            run_command(1'b1, idx % 16, idx / 16);
        end
        scan_board();
        report_test(6, "detonation latch");

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== testbench/redraw_board_assert.sv ====
`timescale 1ns/1ps

module redraw_board_assert import mines_pkg::*; (
    input logic      clk,
    input logic      rst_n,
    input cell_req_t fetch_req,
    input cell_req_t ram_req,
    input logic      fetch_gnt,
    input logic      defuse_gnt,
    input logic      flag_gnt,
    input logic      explode
);

    // ====================
    // arbiter

    a_one_grant: assert property (
        @(posedge clk) disable iff (!rst_n) $onehot0({fetch_gnt, defuse_gnt, flag_gnt})
    ) else $error("more than one memory grant in one cycle");

    a_fetch_first: assert property (
        @(posedge clk) disable iff (!rst_n)
            fetch_req.valid |-> fetch_gnt && ram_req == fetch_req
    ) else $error("display read left without a grant");

    // ====================
    // detonation latch

    a_explode_held: assert property (
        @(posedge clk) disable iff (!rst_n) !$fell(explode)
    ) else $error("explode fell outside reset");

endmodule

bind redraw_board redraw_board_assert u_assert (
    .clk(clk),
    .rst_n(rst_n),
    .fetch_req(fetch_req),
    .ram_req(ram_req),
    .fetch_gnt(fetch_gnt),
    .defuse_gnt(defuse_gnt),
    .flag_gnt(flag_gnt),
    .explode(explode)
);

// ==== verilog/redraw_board.sv ====
`timescale 1ns/1ps

module redraw_board import mines_pkg::*; #(
    parameter int MAX_SIDE = 16
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         mark_flag,
    input  logic                         defuse,
    input  logic [3:0]                   symbol_x,
    input  logic [3:0]                   symbol_y,
    input  level_t                       level,
    input  logic [MAX_SIDE*MAX_SIDE-1:0] mine_map,
    input  logic                         scan_valid,
    input  logic [3:0]                   scan_x,
    input  logic [3:0]                   scan_y,
    output logic                         symbol_valid,
    output symbol_t                      symbol,
    output logic                         explode,
    output logic [3:0]                   blast_x,
    output logic [3:0]                   blast_y,
    output logic [5:0]                   mines,
    output logic [5:0]                   mines_left,
    output logic                         busy
);

    cell_req_t fetch_req;
    cell_req_t defuse_req;
    cell_req_t flag_req;
    cell_req_t ram_req;
    cell_t     rdata;    // shared by all three clients
    logic      fetch_gnt;
    logic      defuse_gnt;
    logic      flag_gnt;
    logic      flag_busy;
    logic      defuse_busy;

    assign busy = flag_busy | defuse_busy;

    // ====================
    // clients

    flag_marker #(.MAX_SIDE(MAX_SIDE)) u_flag_marker (
        .clk, .rst_n, .mark_flag, .symbol_x, .symbol_y, .level, .mine_map,
        .exploded(explode),
        .gnt(flag_gnt),
        .rdata,
        .req(flag_req),
        .busy(flag_busy),
        .mines,
        .mines_left
    );

    defuse_unit #(.MAX_SIDE(MAX_SIDE)) u_defuse_unit (
        .clk, .rst_n, .defuse, .symbol_x, .symbol_y, .level, .mine_map,
        .gnt(defuse_gnt),
        .rdata,
        .req(defuse_req),
        .busy(defuse_busy),
        .explode, .blast_x, .blast_y
    );

    symbol_fetch #(.MAX_SIDE(MAX_SIDE)) u_symbol_fetch (
        .clk, .rst_n, .scan_valid, .scan_x, .scan_y, .mine_map,
        .explode, .blast_x, .blast_y, .rdata,
        .req(fetch_req),
        .symbol_valid, .symbol
    );

    // ====================
    // shared memory

    cell_arbiter u_cell_arbiter (
        .fetch_req, .defuse_req, .flag_req,
        .fetch_gnt, .defuse_gnt, .flag_gnt,
        .ram_req
    );

    cell_ram #(.MAX_SIDE(MAX_SIDE)) u_cell_ram (
        .clk, .rst_n,
        .req(ram_req),
        .rdata
    );

endmodule

// ==== verilog/symbol_fetch.sv ====
`timescale 1ns/1ps

module symbol_fetch import mines_pkg::*; #(
    parameter int MAX_SIDE = 16
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         scan_valid,
    input  logic [3:0]                   scan_x,
    input  logic [3:0]                   scan_y,
    input  logic [MAX_SIDE*MAX_SIDE-1:0] mine_map,
    input  logic                         explode,
    input  logic [3:0]                   blast_x,
    input  logic [3:0]                   blast_y,
    input  cell_t                        rdata,
    output cell_req_t                    req,
    output logic                         symbol_valid,
    output symbol_t                      symbol
);

    logic       s1_valid;
    logic       s2_valid;
    logic [3:0] s1_x;
    logic [3:0] s1_y;
    logic [3:0] s2_x;
    logic [3:0] s2_y;
    cell_t      s2_cell;
    symbol_t    next_symbol;

    always_comb begin
        req       = '0;
        req.valid = scan_valid;    // always granted
        req.addr  = cell_addr(scan_x, scan_y);
    end

    // ====================
    // pipeline

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid     <= 1'b0;
            s2_valid     <= 1'b0;
            symbol_valid <= 1'b0;
        end else begin
            s1_valid     <= scan_valid;
            s2_valid     <= s1_valid;
            symbol_valid <= s2_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_x    <= scan_x;
        s1_y    <= scan_y;
        s2_x    <= s1_x;
        s2_y    <= s1_y;
        s2_cell <= rdata;    // read data of the stage 1 access
        symbol  <= next_symbol;
    end

    always_comb begin
        next_symbol = '{kind: SYM_HIDDEN, count: 4'd0};
        if (explode && s2_x == blast_x && s2_y == blast_y &&
            mine_map[cell_addr(s2_x, s2_y)]) begin
            next_symbol.kind = SYM_MINE;
        end else if (s2_cell.flagged) begin
            next_symbol.kind = SYM_FLAG;
        end else if (s2_cell.revealed) begin
            next_symbol.kind  = SYM_NUMBER;
            next_symbol.count = s2_cell.count;
        end
    end

endmodule

// ==== verilog/defuse_unit.sv ====
`timescale 1ns/1ps

module defuse_unit import mines_pkg::*; #(
    parameter int MAX_SIDE = 16
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         defuse,
    input  logic [3:0]                   symbol_x,
    input  logic [3:0]                   symbol_y,
    input  level_t                       level,
    input  logic [MAX_SIDE*MAX_SIDE-1:0] mine_map,
    input  logic                         gnt,
    input  cell_t                        rdata,
    output cell_req_t                    req,
    output logic                         busy,
    output logic                         explode,
    output logic [3:0]                   blast_x,
    output logic [3:0]                   blast_y
);

    unit_state_t state;
    level_t      level_q;
    logic        btn_q;
    logic        edge_q;
    logic        rise;
    logic        in_board;
    logic [4:0]  side;
    logic [3:0]  cur_x;
    logic [3:0]  cur_y;
    logic        is_mine;
    logic [3:0]  nbr_count;
    cell_t       new_cell;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            level_q <= level;
        end
    end

    assign side     = side_of(level_q);
    assign in_board = ({1'b0, symbol_x} < side) && ({1'b0, symbol_y} < side);
    assign rise     = defuse && !btn_q && !busy;
    assign busy     = edge_q || (state != ST_IDLE);
    assign is_mine  = mine_map[cell_addr(cur_x, cur_y)];

    // ====================
    // neighbour mine count

    always_comb begin
        nbr_count = '0;
        for (int dy = -1; dy <= 1; dy++) begin
            for (int dx = -1; dx <= 1; dx++) begin
                int nx;
                int ny;
                nx = int'(cur_x) + dx;
                ny = int'(cur_y) + dy;
                // skip the centre and anything off the board
                if (!(dx == 0 && dy == 0) && nx >= 0 && ny >= 0 &&
                    nx < int'(side) && ny < int'(side)) begin
                    nbr_count = nbr_count + {3'b000, mine_map[cell_addr(4'(nx), 4'(ny))]};
                end
            end
        end
    end

    // ====================
    // command FSM

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            btn_q   <= 1'b0;
            edge_q  <= 1'b0;
            state   <= ST_IDLE;
            explode <= 1'b0;
            blast_x <= '0;
            blast_y <= '0;
        end else begin
            btn_q  <= defuse;
            edge_q <= rise && in_board && !explode;    // nothing after a detonation
            case (state)
                ST_IDLE: if (edge_q) state <= ST_READ;
                ST_READ: if (gnt) state <= ST_WAIT;
                ST_WAIT: begin
                    if (rdata.flagged || rdata.revealed) begin
                        state <= ST_IDLE;
                    end else if (is_mine) begin
                        explode <= 1'b1;    // latched until reset
                        blast_x <= cur_x;
                        blast_y <= cur_y;
                        state   <= ST_IDLE;
                    end else begin
                        state <= ST_WRITE;
                    end
                end
                ST_WRITE: if (gnt) state <= ST_IDLE;
                default:  state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rise) begin
            cur_x <= symbol_x;
            cur_y <= symbol_y;
        end
        if (state == ST_WAIT) begin
            new_cell <= '{flagged: 1'b0, revealed: 1'b1, count: nbr_count};
        end
    end

    always_comb begin
        req       = '0;
        req.valid = (state == ST_READ) || (state == ST_WRITE);
        req.we    = (state == ST_WRITE);
        req.addr  = cell_addr(cur_x, cur_y);
        req.wdata = new_cell;
    end

endmodule

// ==== verilog/flag_marker.sv ====
`timescale 1ns/1ps

module flag_marker import mines_pkg::*; #(
    parameter int MAX_SIDE = 16
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         mark_flag,
    input  logic [3:0]                   symbol_x,
    input  logic [3:0]                   symbol_y,
    input  level_t                       level,
    input  logic [MAX_SIDE*MAX_SIDE-1:0] mine_map,
    input  logic                         exploded,
    input  logic                         gnt,
    input  cell_t                        rdata,
    output cell_req_t                    req,
    output logic                         busy,
    output logic [5:0]                   mines,
    output logic [5:0]                   mines_left
);

    unit_state_t state;
    level_t      level_q;
    logic        btn_q;
    logic        edge_q;
    logic        rise;
    logic        in_board;
    logic [4:0]  side;
    logic [3:0]  cur_x;
    logic [3:0]  cur_y;
    cell_t       new_cell;
    logic [5:0]  flags;
    logic [5:0]  mine_sum;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            level_q <= level;    // level only changes across a reset
        end
    end

    assign side     = side_of(level_q);
    assign in_board = ({1'b0, symbol_x} < side) && ({1'b0, symbol_y} < side);
    assign rise     = mark_flag && !btn_q && !busy;    // edges dropped while busy
    assign busy     = edge_q || (state != ST_IDLE);

    // ====================
    // button edge and command FSM

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            btn_q  <= 1'b0;
            edge_q <= 1'b0;
            state  <= ST_IDLE;
            flags  <= '0;
        end else begin
            btn_q  <= mark_flag;
            edge_q <= rise && in_board && !exploded;
            case (state)
                ST_IDLE:  if (edge_q) state <= ST_READ;
                ST_READ:  if (gnt) state <= ST_WAIT;
                ST_WAIT:  state <= rdata.revealed ? ST_IDLE : ST_WRITE;    // revealed stays
                ST_WRITE: begin
                    if (gnt) begin
                        state <= ST_IDLE;
                        flags <= new_cell.flagged ? flags + 6'd1 : flags - 6'd1;
                    end
                end
                default:  state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rise) begin
            cur_x <= symbol_x;
            cur_y <= symbol_y;
        end
        if (state == ST_WAIT) begin
            new_cell <= '{flagged: !rdata.flagged, revealed: rdata.revealed, count: rdata.count};
        end
    end

    always_comb begin
        req       = '0;
        req.valid = (state == ST_READ) || (state == ST_WRITE);
        req.we    = (state == ST_WRITE);
        req.addr  = cell_addr(cur_x, cur_y);
        req.wdata = new_cell;
    end

    // ====================
    // mine and flag counts

    always_comb begin
        mine_sum = '0;
        for (int y = 0; y < MAX_SIDE; y++) begin
            for (int x = 0; x < MAX_SIDE; x++) begin
                if (x < side && y < side && mine_map[cell_addr(4'(x), 4'(y))]) begin
                    mine_sum = mine_sum + 6'd1;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mines <= '0;
        end else begin
            mines <= mine_sum;
        end
    end

    assign mines_left = (mines > flags) ? mines - flags : 6'd0;    // clamp at zero

endmodule

// ==== verilog/cell_arbiter.sv ====
`timescale 1ns/1ps

module cell_arbiter import mines_pkg::*; (
    input  cell_req_t fetch_req,
    input  cell_req_t defuse_req,
    input  cell_req_t flag_req,
    output logic      fetch_gnt,
    output logic      defuse_gnt,
    output logic      flag_gnt,
    output cell_req_t ram_req
);

    // ====================
    // fixed priority fetch > defuse > flag

    always_comb begin
        fetch_gnt  = fetch_req.valid;                           // display never stalls
        defuse_gnt = defuse_req.valid && !fetch_req.valid;
        flag_gnt   = flag_req.valid && !fetch_req.valid && !defuse_req.valid;
    end

    always_comb begin
        if (fetch_gnt) begin
            ram_req = fetch_req;
        end else if (defuse_gnt) begin
            ram_req = defuse_req;
        end else if (flag_gnt) begin
            ram_req = flag_req;
        end else begin
            ram_req = '0;    // idle cycle with no access
        end
    end

endmodule

// ==== verilog/cell_ram.sv ====
`timescale 1ns/1ps

module cell_ram import mines_pkg::*; #(
    parameter int MAX_SIDE = 16
) (
    input  logic      clk,
    input  logic      rst_n,
    input  cell_req_t req,
    output cell_t     rdata
);

    localparam int DEPTH = MAX_SIDE * MAX_SIDE;

    cell_t mem [DEPTH];

    // one port whose registered read data shows the old value on a write
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;    // new game starts with a blank board
            end
            rdata <= '0;
        end else if (req.valid) begin
            rdata <= mem[req.addr];
            if (req.we) begin
                mem[req.addr] <= req.wdata;
            end
        end
    end

endmodule

// ==== verilog/mines_pkg.sv ====
package mines_pkg;

    // ====================
    // enums

    typedef enum logic [1:0] {
        LVL_EASY,
        LVL_MEDIUM,
        LVL_HARD
    } level_t;

    typedef enum logic [1:0] {
        SYM_HIDDEN,
        SYM_FLAG,
        SYM_NUMBER,
        SYM_MINE
    } symbol_kind_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_READ,
        ST_WAIT,
        ST_WRITE
    } unit_state_t;

    // ====================
    // structs

    typedef struct packed {
        logic       flagged;
        logic       revealed;
        logic [3:0] count;    // neighbour mines from 0 to 8
    } cell_t;

    typedef struct packed {
        logic       valid;
        logic       we;
        logic [7:0] addr;
        cell_t      wdata;
    } cell_req_t;

    typedef struct packed {
        symbol_kind_t kind;
        logic [3:0]   count;
    } symbol_t;

    // ====================
    // board helpers

    function automatic logic [4:0] side_of(input level_t lvl);
        case (lvl)
            LVL_EASY:   return 5'd8;
            LVL_MEDIUM: return 5'd10;
            default:    return 5'd16;
        endcase
    endfunction

    function automatic logic [7:0] cell_addr(input logic [3:0] x, input logic [3:0] y);
        return {y, x};    // row stride of 16
    endfunction

endpackage
